/* src.f */
design/mem_pkg.sv
design/l1_cache.sv
design/flush_ctrl.sv
design/be_merge.sv
design/ext_mem.sv
tests/mem_model.sv
tests/tb_ext_mem.sv

/* Makefile */
TOP = tb_ext_mem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_ext_mem.sv */
`timescale 1ns/1ps

module tb_ext_mem;

   localparam int TIMEOUT_CYC = 40;
   localparam int N_OPS = 12;   // Operations per port in the concurrent test

   logic clk = 1'b0;
   logic rst;
   logic [mem_pkg::N_PORTS-1:0] p_valid;
   mem_pkg::addr_t p_addr [mem_pkg::N_PORTS];
   mem_pkg::data_t p_wdata [mem_pkg::N_PORTS];
   mem_pkg::strb_t p_wstrb [mem_pkg::N_PORTS];
   mem_pkg::data_t p_rdata [mem_pkg::N_PORTS];
   logic [mem_pkg::N_PORTS-1:0] p_ready;
   logic flush;
   logic flush_busy;
   logic mem_valid;
   logic mem_ready;
   mem_pkg::addr_t mem_addr;
   mem_pkg::data_t mem_wdata;
   mem_pkg::data_t mem_rdata;
   mem_pkg::strb_t mem_wstrb;
   int acc_count;

   mem_pkg::data_t ref_mem [1 << mem_pkg::ADDR_W];   // Expected memory contents
   mem_pkg::addr_t op_addr [mem_pkg::N_PORTS][N_OPS];
   mem_pkg::data_t op_data [mem_pkg::N_PORTS][N_OPS];
   mem_pkg::strb_t op_strb [mem_pkg::N_PORTS][N_OPS];
   logic [31:0] lfsr;
   logic timed_out = 1'b0;
   int errors = 0;
   int n_tests = 0;
   int n_passed = 0;

   ext_mem i_dut (.*);
   mem_model i_mem (.*);

   always #10 clk = ~clk;

   // Galois LFSR, one step per bit
   function automatic logic rand_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
         lfsr = lfsr ^ 32'h80200003;
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], rand_bit()};
      end
      return v;
   endfunction

   // Bytes with a set strobe take the new data
   function automatic mem_pkg::data_t apply_strobes(input mem_pkg::data_t old,
                                                    input mem_pkg::data_t new_d,
                                                    input mem_pkg::strb_t s);
      mem_pkg::data_t r;
      r = old;
      for (int b = 0; b < mem_pkg::STRB_W; b++) begin
         if (s[b]) begin
            r[8*b +: 8] = new_d[8*b +: 8];
         end
      end
      return r;
   endfunction

   task automatic compare_word(input string name, input mem_pkg::data_t exp,
                               input mem_pkg::data_t act);
      assert (act === exp) else begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic require(input logic cond, input string what);
      assert (cond) else begin
         $display("Error: %s", what);
         errors++;
      end
   endtask

   task automatic close_test(input string name, input int err_before);
      n_tests++;
      if (errors == err_before) begin
         n_passed++;
         $display("Test %s: passed", name);
      end else begin
         $display("Test %s: failed with %0d errors", name, errors - err_before);
      end
   endtask

   // One front-end request, held until ready
   task automatic do_access(input int port, input mem_pkg::addr_t a, input mem_pkg::data_t d,
                            input mem_pkg::strb_t s, output mem_pkg::data_t rd);
      int n;
      rd = '0;
      if (timed_out) return;
      @(posedge clk);
      #1 p_valid[port] = 1'b1;
      p_addr[port]  = a;
      p_wdata[port] = d;
      p_wstrb[port] = s;
      n = 0;
      @(negedge clk);
      while (!p_ready[port] && n < TIMEOUT_CYC) begin
         @(negedge clk);
         n++;
      end
      if (!p_ready[port]) begin
         $display("Error: port %0d got no ready for address %h", port, a);
         timed_out = 1'b1;
         errors++;
      end
      rd = p_rdata[port];
      @(posedge clk);
      #1 p_valid[port] = 1'b0;
      p_wstrb[port] = '0;
   endtask

   task automatic pulse_flush();
      int n;
      @(posedge clk);
      #1 flush = 1'b1;
      @(posedge clk);
      #1 flush = 1'b0;
      require(flush_busy, "flush_busy did not rise after the flush pulse");
      n = 0;
      while (flush_busy && n < TIMEOUT_CYC) begin
         @(negedge clk);
         n++;
      end
      if (flush_busy) begin
         $display("Error: flush_busy never fell after the flush pulse");
         timed_out = 1'b1;
         errors++;
      end
   endtask

   task automatic check_reset_state();
      int e0;
      int c0;
      mem_pkg::addr_t a;
      mem_pkg::data_t rd;
      e0 = errors;
      require(p_ready == '0, "p_ready is high after reset");
      require(!mem_valid, "mem_valid is high after reset");
      require(!flush_busy, "flush_busy is high after reset");
      for (int p = 0; p < mem_pkg::N_PORTS; p++) begin
         a = mem_pkg::addr_t'(32'h0123 + 32'h1111 * p);
         c0 = acc_count;
         do_access(p, a, '0, '0, rd);
         compare_word("reset_state", ref_mem[a], rd);
         compare_word("reset_state", mem_pkg::data_t'(c0 + 1), mem_pkg::data_t'(acc_count));
      end
      close_test("reset_state", e0);
   endtask

   task automatic write_read_back();
      int e0;
      int c0;
      mem_pkg::addr_t a;
      mem_pkg::data_t d;
      mem_pkg::data_t rd;
      e0 = errors;
      for (int i = 0; i < 4; i++) begin
         a = mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W - 1));   // Lower half
         d = rand_bits(32);
         do_access(0, a, d, 4'hF, rd);
         ref_mem[a] = d;
         compare_word("write_read_back", d, i_mem.mem[a]);
         do_access(0, a, '0, '0, rd);   // Miss, write did not allocate
         compare_word("write_read_back", d, rd);
         c0 = acc_count;
         do_access(0, a, '0, '0, rd);
         compare_word("write_read_back", d, rd);
         compare_word("write_read_back", mem_pkg::data_t'(c0), mem_pkg::data_t'(acc_count));
      end
      close_test("write_read_back", e0);
   endtask

   task automatic strobe_merge();
      int e0;
      int c0;
      mem_pkg::addr_t a;
      mem_pkg::data_t d;
      mem_pkg::data_t rd;
      mem_pkg::strb_t strobes [3] = '{4'b0101, 4'b1000, 4'b0110};
      e0 = errors;
      a = mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W - 1));
      do_access(0, a, '0, '0, rd);   // Bring the line in
      compare_word("strobe_merge", ref_mem[a], rd);
      for (int i = 0; i < 3; i++) begin
         d = rand_bits(32);
         do_access(0, a, d, strobes[i], rd);
         ref_mem[a] = apply_strobes(ref_mem[a], d, strobes[i]);
         c0 = acc_count;
         do_access(0, a, '0, '0, rd);
         compare_word("strobe_merge", ref_mem[a], rd);
         compare_word("strobe_merge", ref_mem[a], i_mem.mem[a]);
         compare_word("strobe_merge", mem_pkg::data_t'(c0), mem_pkg::data_t'(acc_count));
      end
      close_test("strobe_merge", e0);
   endtask

   task automatic stale_copy_flush();
      int e0;
      int c0;
      mem_pkg::addr_t a;
      mem_pkg::data_t old;
      mem_pkg::data_t d;
      mem_pkg::data_t rd;
      e0 = errors;
      a = 14'h2A5A;
      old = ref_mem[a];
      do_access(1, a, '0, '0, rd);
      compare_word("stale_copy_flush", old, rd);
      d = rand_bits(32);
      do_access(0, a, d, 4'hF, rd);
      ref_mem[a] = d;
      do_access(1, a, '0, '0, rd);   // No coherence, old copy expected
      compare_word("stale_copy_flush", old, rd);
      pulse_flush();
      c0 = acc_count;
      do_access(1, a, '0, '0, rd);
      compare_word("stale_copy_flush", d, rd);
      compare_word("stale_copy_flush", mem_pkg::data_t'(c0 + 1), mem_pkg::data_t'(acc_count));
      close_test("stale_copy_flush", e0);
   endtask

   task automatic drive_port_traffic(input int port);
      mem_pkg::addr_t a;
      mem_pkg::data_t rd;
      for (int i = 0; i < N_OPS; i++) begin
         a = op_addr[port][i];
         do_access(port, a, op_data[port][i], op_strb[port][i], rd);
         if (op_strb[port][i] != '0) begin
            ref_mem[a] = apply_strobes(ref_mem[a], op_data[port][i], op_strb[port][i]);
         end else begin
            compare_word("concurrent_traffic", ref_mem[a], rd);
         end
      end
   endtask

   task automatic concurrent_traffic();
      int e0;
      e0 = errors;
      // Port 0 in the lower half, port 1 in the upper half
      for (int p = 0; p < mem_pkg::N_PORTS; p++) begin
         for (int i = 0; i < N_OPS; i++) begin
            op_addr[p][i] = mem_pkg::addr_t'(rand_bits(6) + 32'h2000 * p);
            op_data[p][i] = rand_bits(32);
            op_strb[p][i] = rand_bit() ? mem_pkg::strb_t'(rand_bits(4)) : 4'h0;
         end
      end
      fork
         drive_port_traffic(0);
         drive_port_traffic(1);
      join
      for (int p = 0; p < mem_pkg::N_PORTS; p++) begin
         for (int i = 0; i < N_OPS; i++) begin
            compare_word("concurrent_traffic", ref_mem[op_addr[p][i]], i_mem.mem[op_addr[p][i]]);
         end
      end
      close_test("concurrent_traffic", e0);
   endtask

   initial begin
      rst = 1'b1;
      flush = 1'b0;
      p_valid = '0;
      for (int p = 0; p < mem_pkg::N_PORTS; p++) begin
         p_addr[p]  = '0;
         p_wdata[p] = '0;
         p_wstrb[p] = '0;
      end
      lfsr = 32'd89269;
      repeat (3) @(posedge clk);
      #1 rst = 1'b0;
      for (int a = 0; a < (1 << mem_pkg::ADDR_W); a++) begin
         ref_mem[a] = i_mem.mem[a];   // Start from the model's fill
      end
      check_reset_state();
      if (!timed_out) write_read_back();
      if (!timed_out) strobe_merge();
      if (!timed_out) stale_copy_flush();
      if (!timed_out) concurrent_traffic();
      $display("%0d tests run, %0d passed, %0d failed, %0d errors",
               n_tests, n_passed, n_tests - n_passed, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* tests/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
   input  logic           clk,
   input  logic           rst,
   input  logic           mem_valid,
   input  mem_pkg::addr_t mem_addr,
   input  mem_pkg::data_t mem_wdata,
   input  mem_pkg::strb_t mem_wstrb,
   output mem_pkg::data_t mem_rdata,
   output logic           mem_ready,
   output int             acc_count    // Completed memory accesses
);

   mem_pkg::data_t mem [1 << mem_pkg::ADDR_W];
   int wait_cnt;

   // Fill pattern built from the whole word address
   initial begin
      for (int a = 0; a < (1 << mem_pkg::ADDR_W); a++) begin
         mem[a] = {2'b10, mem_pkg::addr_t'(a), 2'b01, ~mem_pkg::addr_t'(a)};
      end
   end

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         mem_ready <= 1'b0;
         mem_rdata <= '0;
         wait_cnt  <= 0;
         acc_count <= 0;
      end else if (mem_ready) begin
         mem_ready <= 1'b0;   // One ready cycle per request
         wait_cnt  <= 0;
      end else if (mem_valid) begin
         if (wait_cnt == 1) begin
            mem_ready <= 1'b1;
            mem_rdata <= mem[mem_addr];   // Old word, sampled before the write
            acc_count <= acc_count + 1;
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
               if (mem_wstrb[b]) begin
                  mem[mem_addr][8*b +: 8] = mem_wdata[8*b +: 8];
               end
            end
         end else begin
            wait_cnt <= wait_cnt + 1;
         end
      end
   end

endmodule

/* design/ext_mem.sv */
`timescale 1ns/1ps

module ext_mem (
   input  logic                        clk,
   input  logic                        rst,
   // Front-end masters
   input  logic [mem_pkg::N_PORTS-1:0] p_valid,
   input  mem_pkg::addr_t              p_addr [mem_pkg::N_PORTS],
   input  mem_pkg::data_t              p_wdata [mem_pkg::N_PORTS],
   input  mem_pkg::strb_t              p_wstrb [mem_pkg::N_PORTS],
   output mem_pkg::data_t              p_rdata [mem_pkg::N_PORTS],
   output logic [mem_pkg::N_PORTS-1:0] p_ready,
   // Cache flush
   input  logic                        flush,
   output logic                        flush_busy,
   // External memory
   output logic                        mem_valid,
   output mem_pkg::addr_t              mem_addr,
   output mem_pkg::data_t              mem_wdata,
   output mem_pkg::strb_t              mem_wstrb,
   input  mem_pkg::data_t              mem_rdata,
   input  logic                        mem_ready
);

   // Cache back-end buses into the merge
   logic [mem_pkg::N_PORTS-1:0] be_valid;
   mem_pkg::addr_t              be_addr [mem_pkg::N_PORTS];
   mem_pkg::data_t              be_wdata [mem_pkg::N_PORTS];
   mem_pkg::strb_t              be_wstrb [mem_pkg::N_PORTS];
   mem_pkg::data_t              be_rdata;   // Shared, qualified per cache by be_ready
   logic [mem_pkg::N_PORTS-1:0] be_ready;

   logic invalidate;

   flush_ctrl i_flush (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .mem_valid  (mem_valid),
      .invalidate (invalidate),
      .flush_busy (flush_busy)
   );

   for (genvar i = 0; i < mem_pkg::N_PORTS; i++) begin : g_cache
      l1_cache i_cache (
         .clk        (clk),
         .rst        (rst),
         .invalidate (invalidate),
         .p_valid    (p_valid[i]),
         .p_addr     (p_addr[i]),
         .p_wdata    (p_wdata[i]),
         .p_wstrb    (p_wstrb[i]),
         .p_rdata    (p_rdata[i]),
         .p_ready    (p_ready[i]),
         .be_valid   (be_valid[i]),
         .be_addr    (be_addr[i]),
         .be_wdata   (be_wdata[i]),
         .be_wstrb   (be_wstrb[i]),
         .be_rdata   (be_rdata),
         .be_ready   (be_ready[i])
      );
   end

   be_merge i_merge (
      .clk       (clk),
      .rst       (rst),
      .c_valid   (be_valid),
      .c_addr    (be_addr),
      .c_wdata   (be_wdata),
      .c_wstrb   (be_wstrb),
      .c_rdata   (be_rdata),
      .c_ready   (be_ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

endmodule

/* design/be_merge.sv */
`timescale 1ns/1ps

module be_merge (
   input  logic                        clk,
   input  logic                        rst,
   // Cache back-ends
   input  logic [mem_pkg::N_PORTS-1:0] c_valid,
   input  mem_pkg::addr_t              c_addr [mem_pkg::N_PORTS],
   input  mem_pkg::data_t              c_wdata [mem_pkg::N_PORTS],
   input  mem_pkg::strb_t              c_wstrb [mem_pkg::N_PORTS],
   output mem_pkg::data_t              c_rdata,
   output logic [mem_pkg::N_PORTS-1:0] c_ready,
   // Memory port
   output logic                        mem_valid,
   output mem_pkg::addr_t              mem_addr,
   output mem_pkg::data_t              mem_wdata,
   output mem_pkg::strb_t              mem_wstrb,
   input  mem_pkg::data_t              mem_rdata,
   input  logic                        mem_ready
);

   mem_pkg::port_t ptr;    // Last granted port, the live grant while busy
   mem_pkg::port_t sel;
   mem_pkg::port_t cand;
   logic           busy;

   // Round-robin pick, searched from the port after ptr
   always_comb begin
      sel  = ptr;
      cand = ptr;
      for (int off = mem_pkg::N_PORTS; off >= 1; off--) begin
         cand = mem_pkg::port_t'((int'(ptr) + off) % mem_pkg::N_PORTS);
         if (c_valid[cand]) begin
            sel = cand;   // Nearest one is checked last and wins
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         ptr  <= mem_pkg::port_t'(mem_pkg::N_PORTS - 1);   // Port 0 goes first
      end else if (!busy) begin
         if (|c_valid) begin
            busy <= 1'b1;
            ptr  <= sel;
         end
      end else if (mem_ready) begin
         busy <= 1'b0;
      end
   end

   // Request payload, captured with the grant
   always_ff @(posedge clk) begin
      if (!busy && (|c_valid)) begin
         mem_addr  <= c_addr[sel];
         mem_wdata <= c_wdata[sel];
         mem_wstrb <= c_wstrb[sel];
      end
   end

   assign mem_valid = busy;

   // Response goes back to the granted cache only
   always_comb begin
      c_ready = '0;
      if (busy && mem_ready) begin
         c_ready[ptr] = 1'b1;
      end
   end

   assign c_rdata = mem_rdata;   // Qualified by c_ready

   // Answer only to a cache that still holds its request
   a_ready_req : assert property (@(posedge clk) disable iff (rst)
      (c_ready & ~c_valid) == '0)
      else $error("be_merge: ready sent to a cache without a request");

   a_mem_hold : assert property (@(posedge clk) disable iff (rst)
      (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr)))
      else $error("be_merge: memory request dropped before ready");

endmodule

/* design/flush_ctrl.sv */
`timescale 1ns/1ps

module flush_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic flush,        // One-cycle request
   input  logic mem_valid,    // Merged back-end bus
   output logic invalidate,
   output logic flush_busy
);

   logic pending;

   // Fires on the first idle bus cycle after the request
   assign invalidate = pending && !mem_valid;
   assign flush_busy = pending;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pending <= 1'b0;
      end else if (flush) begin
         pending <= 1'b1;   // A new request always wins
      end else if (invalidate) begin
         pending <= 1'b0;
      end
   end

   // Flush request comes as a single-cycle pulse
   a_flush_pulse : assert property (@(posedge clk) disable iff (rst)
      flush |=> !flush)
      else $error("flush_ctrl: flush request held longer than one cycle");

endmodule

/* design/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache (
   input  logic           clk,
   input  logic           rst,
   input  logic           invalidate,
   // Front-end
   input  logic           p_valid,
   input  mem_pkg::addr_t p_addr,
   input  mem_pkg::data_t p_wdata,
   input  mem_pkg::strb_t p_wstrb,
   output mem_pkg::data_t p_rdata,
   output logic           p_ready,
   // Back-end towards the merge
   output logic           be_valid,
   output mem_pkg::addr_t be_addr,
   output mem_pkg::data_t be_wdata,
   output mem_pkg::strb_t be_wstrb,
   input  mem_pkg::data_t be_rdata,
   input  logic           be_ready
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_BE_WAIT,
      ST_RESPOND
   } cache_state_t;

   cache_state_t state;

   mem_pkg::tag_t  tag_mem [mem_pkg::N_LINES];
   mem_pkg::data_t data_mem [mem_pkg::N_LINES];
   logic [mem_pkg::N_LINES-1:0] vld;   // One valid bit per line

   mem_pkg::index_t idx;
   mem_pkg::tag_t   tag;
   mem_pkg::tag_t   tag_rd;
   mem_pkg::data_t  data_rd;
   mem_pkg::data_t  merged;

   logic is_wr;
   logic hit;
   logic hit_q;       // Lookup result, kept for the write-hit update
   logic fill_done;
   logic wr_update;

   assign idx   = p_addr[mem_pkg::INDEX_W-1:0];
   assign tag   = p_addr[mem_pkg::ADDR_W-1:mem_pkg::INDEX_W];
   assign is_wr = |p_wstrb;

   // Valid only in the lookup cycle, when tag_rd belongs to this request
   assign hit = vld[idx] && (tag_rd == tag);

   assign fill_done = (state == ST_BE_WAIT) && be_ready && !is_wr;
   assign wr_update = (state == ST_BE_WAIT) && be_ready && is_wr && hit_q;

   // Byte merge of the write into the stored word
   always_comb begin
      for (int b = 0; b < mem_pkg::STRB_W; b++) begin
         merged[8*b +: 8] = p_wstrb[b] ? p_wdata[8*b +: 8] : data_rd[8*b +: 8];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= ST_IDLE;
         hit_q <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (p_valid) begin
                  state <= ST_LOOKUP;
               end
            end
            ST_LOOKUP: begin
               hit_q <= hit;
               if (hit && !is_wr) begin
                  state <= ST_IDLE;   // Read hit answered this cycle
               end else begin
                  state <= ST_BE_WAIT;
               end
            end
            ST_BE_WAIT: begin
               if (be_ready) begin
                  state <= ST_RESPOND;
               end
            end
            ST_RESPOND: state <= ST_IDLE;
            default:    state <= ST_IDLE;
         endcase
      end
   end

   // Valid bits; a flush wins over a fill in the same cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vld <= '0;
      end else if (invalidate) begin
         vld <= '0;
      end else if (fill_done) begin
         vld[idx] <= 1'b1;
      end
   end

   // Tag and data arrays with registered read
   always_ff @(posedge clk) begin
      if (state == ST_IDLE) begin
         tag_rd  <= tag_mem[idx];
         data_rd <= data_mem[idx];
      end else if (fill_done) begin
         data_rd <= be_rdata;   // Returned in the respond cycle
      end
      if (fill_done) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= be_rdata;
      end else if (wr_update) begin
         data_mem[idx] <= merged;
      end
   end

   assign p_ready = ((state == ST_LOOKUP) && hit && !is_wr) || (state == ST_RESPOND);
   assign p_rdata = data_rd;

   // Requester holds the fields, so they go straight to the back-end
   assign be_valid = (state == ST_BE_WAIT);
   assign be_addr  = p_addr;
   assign be_wdata = p_wdata;
   assign be_wstrb = p_wstrb;

   // Requester keeps its request steady until it is answered
   a_fe_stable : assert property (@(posedge clk) disable iff (rst)
      (p_valid && !p_ready) |=>
         (p_valid && $stable(p_addr) && $stable(p_wdata) && $stable(p_wstrb)))
      else $error("l1_cache: front-end request changed before ready");

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

   // Front-end masters, one cache each
   localparam int N_PORTS = 2;

   // Bus geometry, word addressed
   localparam int ADDR_W = 14;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;   // One strobe per byte

   // Direct-mapped cache with one-word lines
   localparam int INDEX_W = 5;
   localparam int TAG_W   = ADDR_W - INDEX_W;
   localparam int N_LINES = 1 << INDEX_W;   // 32 lines

   // Port number inside the merge
   localparam int PORT_W = $clog2(N_PORTS);

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [STRB_W-1:0]  strb_t;
   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [PORT_W-1:0]  port_t;

endpackage
